//--- spike_pkg.sv
`default_nettype none

// Spike flit layout, most significant field first:
//   dx             signed hop offset, COORD_W bits
//   dy             signed hop offset, COORD_W bits
//   axon_id        target axon on the destination core
//   delivery_tick  tick slot for the scheduler
//   debug          carried through untouched
// The last three fields form the payload in the low bits of a flit.
// The payload is also the whole word handed to the local core.
package spike_pkg;

    // Payload field widths
    localparam int AXON_W = 8;
    localparam int TICK_W = 4;
    localparam int DEBUG_W = 2;

    // Payload width, also the local delivery word
    localparam int DELIVERY_W = AXON_W + TICK_W + DEBUG_W;

    // Word to the local scheduler: {axon_id, delivery_tick, debug}
    typedef logic [DELIVERY_W-1:0] delivery_t;

endpackage

`default_nettype wire

//--- route_pkg.sv
`default_nettype none

// Routing decisions and output port indices share one encoding
package route_pkg;

    // Mesh ports follow DIR_LOCAL in this order
    typedef enum logic [2:0] {
        DIR_LOCAL = 3'd0,
        DIR_NORTH = 3'd1,
        DIR_SOUTH = 3'd2,
        DIR_EAST  = 3'd3,
        DIR_WEST  = 3'd4
    } port_dir_e;

    // One output register per direction
    localparam int NUM_OUT_PORTS = 5;

endpackage

`default_nettype wire

//--- input_port.sv
`default_nettype none

// One-entry input buffer with X-first route decode.
// The buffered flit is offered to the switch already rewritten
// for the next hop.
module input_port #(
    parameter int COORD_W = 9,
    localparam int FLIT_W = 2 * COORD_W + spike_pkg::DELIVERY_W
) (
    input  logic                 clk,
    input  logic                 rst,

    // Upstream side
    input  logic [FLIT_W-1:0]    in_data,
    input  logic                 in_valid,
    output logic                 in_ready,

    // Request to the output switch
    output logic                 req_valid,
    output route_pkg::port_dir_e req_dir,
    output logic [FLIT_W-1:0]    req_flit,
    input  logic                 grant
);

    // Field positions inside a flit
    localparam int DY_LSB = spike_pkg::DELIVERY_W;
    localparam int DX_LSB = DY_LSB + COORD_W;

    localparam logic signed [COORD_W-1:0] STEP = COORD_W'(1);

    logic [FLIT_W-1:0]                flit_q;
    logic                             flit_vld;
    logic                             take;
    logic signed [COORD_W-1:0]        dx;
    logic signed [COORD_W-1:0]        dy;
    logic signed [COORD_W-1:0]        next_dx;
    logic signed [COORD_W-1:0]        next_dy;
    logic [spike_pkg::DELIVERY_W-1:0] payload;

    // Entry frees up on the same edge it is granted
    assign in_ready = !flit_vld || grant;
    assign take = in_valid && in_ready;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            flit_vld <= 1'b0;
        end else if (take) begin
            flit_vld <= 1'b1;
        end else if (grant) begin
            flit_vld <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            flit_q <= in_data;
        end
    end

    assign dx = flit_q[DX_LSB +: COORD_W];
    assign dy = flit_q[DY_LSB +: COORD_W];
    assign payload = flit_q[spike_pkg::DELIVERY_W-1:0];

    // X first, then Y, then deliver
    always_comb begin
        next_dx = dx;
        next_dy = dy;
        if (dx > 0) begin
            req_dir = route_pkg::DIR_EAST;
            next_dx = dx - STEP;
        end else if (dx < 0) begin
            req_dir = route_pkg::DIR_WEST;
            next_dx = dx + STEP;
        end else if (dy > 0) begin
            req_dir = route_pkg::DIR_NORTH;
            next_dx = '0;
            next_dy = dy - STEP;
        end else if (dy < 0) begin
            req_dir = route_pkg::DIR_SOUTH;
            next_dx = '0;
            next_dy = dy + STEP;
        end else begin
            // Arrived, flit goes out unchanged
            req_dir = route_pkg::DIR_LOCAL;
        end
    end

    assign req_valid = flit_vld;
    assign req_flit = {next_dx, next_dy, payload};

endmodule

`default_nettype wire

//--- output_switch.sv
`default_nettype none

// Per-port allocator and output registers.
// Each output port arbitrates on its own, so requests for different
// ports go through in the same cycle. The local input wins a tie.
module output_switch #(
    parameter int COORD_W = 9,
    localparam int FLIT_W = 2 * COORD_W + spike_pkg::DELIVERY_W
) (
    input  logic                 clk,
    input  logic                 rst,

    // Request from the local input port
    input  logic                 loc_req_valid,
    input  route_pkg::port_dir_e loc_req_dir,
    input  logic [FLIT_W-1:0]    loc_req_flit,

    // Request from the link input port
    input  logic                 lnk_req_valid,
    input  route_pkg::port_dir_e lnk_req_dir,
    input  logic [FLIT_W-1:0]    lnk_req_flit,

    output logic                 loc_grant,
    output logic                 lnk_grant,

    // Delivery to the local core
    output spike_pkg::delivery_t local_out_data,
    output logic                 local_out_valid,
    input  logic                 local_out_ready,

    // Mesh outputs
    output logic [FLIT_W-1:0]    north_out_data,
    output logic                 north_out_valid,
    input  logic                 north_out_ready,

    output logic [FLIT_W-1:0]    south_out_data,
    output logic                 south_out_valid,
    input  logic                 south_out_ready,

    output logic [FLIT_W-1:0]    east_out_data,
    output logic                 east_out_valid,
    input  logic                 east_out_ready,

    output logic [FLIT_W-1:0]    west_out_data,
    output logic                 west_out_valid,
    input  logic                 west_out_ready
);

    localparam int NPORT = route_pkg::NUM_OUT_PORTS;
    // Mesh ports sit above DIR_LOCAL in the encoding
    localparam int FIRST_MESH = int'(route_pkg::DIR_NORTH);

    logic [NPORT-1:0]     out_ready;
    logic [NPORT-1:0]     vld_q;
    logic [NPORT-1:0]     port_free;
    logic [NPORT-1:0]     loc_hit;
    logic [NPORT-1:0]     lnk_hit;
    logic [NPORT-1:0]     loc_take;
    logic [NPORT-1:0]     lnk_take;
    logic [NPORT-1:0]     load;
    logic [FLIT_W-1:0]    win_flit [NPORT];
    logic [FLIT_W-1:0]    mesh_q [FIRST_MESH:NPORT-1];
    spike_pkg::delivery_t local_q;

    assign out_ready[route_pkg::DIR_LOCAL] = local_out_ready;
    assign out_ready[route_pkg::DIR_NORTH] = north_out_ready;
    assign out_ready[route_pkg::DIR_SOUTH] = south_out_ready;
    assign out_ready[route_pkg::DIR_EAST]  = east_out_ready;
    assign out_ready[route_pkg::DIR_WEST]  = west_out_ready;

    always_comb begin
        for (int p = 0; p < NPORT; p++) begin
            // Free if empty or draining on this edge
            port_free[p] = !vld_q[p] || out_ready[p];
            loc_hit[p] = loc_req_valid && (loc_req_dir == route_pkg::port_dir_e'(p));
            lnk_hit[p] = lnk_req_valid && (lnk_req_dir == route_pkg::port_dir_e'(p));
            loc_take[p] = loc_hit[p] && port_free[p];
            // Link only gets a port the local input is not asking for
            lnk_take[p] = lnk_hit[p] && port_free[p] && !loc_hit[p];
            load[p] = loc_take[p] || lnk_take[p];
            win_flit[p] = loc_hit[p] ? loc_req_flit : lnk_req_flit;
        end
    end

    // Each input asks for one port at most
    assign loc_grant = |loc_take;
    assign lnk_grant = |lnk_take;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            vld_q <= '0;
        end else begin
            for (int p = 0; p < NPORT; p++) begin
                if (load[p]) begin
                    vld_q[p] <= 1'b1;
                end else if (out_ready[p]) begin
                    vld_q[p] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        // Local core only sees the payload bits
        if (load[route_pkg::DIR_LOCAL]) begin
            local_q <= win_flit[route_pkg::DIR_LOCAL][spike_pkg::DELIVERY_W-1:0];
        end
        for (int p = FIRST_MESH; p < NPORT; p++) begin
            if (load[p]) begin
                mesh_q[p] <= win_flit[p];
            end
        end
    end

    assign local_out_data  = local_q;
    assign local_out_valid = vld_q[route_pkg::DIR_LOCAL];

    assign north_out_data  = mesh_q[route_pkg::DIR_NORTH];
    assign north_out_valid = vld_q[route_pkg::DIR_NORTH];

    assign south_out_data  = mesh_q[route_pkg::DIR_SOUTH];
    assign south_out_valid = vld_q[route_pkg::DIR_SOUTH];

    assign east_out_data   = mesh_q[route_pkg::DIR_EAST];
    assign east_out_valid  = vld_q[route_pkg::DIR_EAST];

    assign west_out_data   = mesh_q[route_pkg::DIR_WEST];
    assign west_out_valid  = vld_q[route_pkg::DIR_WEST];

endmodule

`default_nettype wire

//--- spike_router.sv
`default_nettype none

// Single mesh node router.
// Local core and one link feed two input buffers. Both share the
// five output registers through the switch.
module spike_router #(
    parameter int COORD_W = 9,
    localparam int FLIT_W = 2 * COORD_W + spike_pkg::DELIVERY_W
) (
    input  logic                 clk,
    input  logic                 rst,

    // Injection from the local core
    input  logic [FLIT_W-1:0]    local_in_data,
    input  logic                 local_in_valid,
    output logic                 local_in_ready,

    // Mesh link input
    input  logic [FLIT_W-1:0]    link_in_data,
    input  logic                 link_in_valid,
    output logic                 link_in_ready,

    // Delivery to the local scheduler
    output spike_pkg::delivery_t local_out_data,
    output logic                 local_out_valid,
    input  logic                 local_out_ready,

    output logic [FLIT_W-1:0]    north_out_data,
    output logic                 north_out_valid,
    input  logic                 north_out_ready,

    output logic [FLIT_W-1:0]    south_out_data,
    output logic                 south_out_valid,
    input  logic                 south_out_ready,

    output logic [FLIT_W-1:0]    east_out_data,
    output logic                 east_out_valid,
    input  logic                 east_out_ready,

    output logic [FLIT_W-1:0]    west_out_data,
    output logic                 west_out_valid,
    input  logic                 west_out_ready
);

    logic                 loc_req_valid;
    route_pkg::port_dir_e loc_req_dir;
    logic [FLIT_W-1:0]    loc_req_flit;
    logic                 loc_grant;

    logic                 lnk_req_valid;
    route_pkg::port_dir_e lnk_req_dir;
    logic [FLIT_W-1:0]    lnk_req_flit;
    logic                 lnk_grant;

    input_port #(.COORD_W(COORD_W)) u_local_port (
        .clk       (clk),
        .rst       (rst),
        .in_data   (local_in_data),
        .in_valid  (local_in_valid),
        .in_ready  (local_in_ready),
        .req_valid (loc_req_valid),
        .req_dir   (loc_req_dir),
        .req_flit  (loc_req_flit),
        .grant     (loc_grant)
    );

    input_port #(.COORD_W(COORD_W)) u_link_port (
        .clk       (clk),
        .rst       (rst),
        .in_data   (link_in_data),
        .in_valid  (link_in_valid),
        .in_ready  (link_in_ready),
        .req_valid (lnk_req_valid),
        .req_dir   (lnk_req_dir),
        .req_flit  (lnk_req_flit),
        .grant     (lnk_grant)
    );

    output_switch #(.COORD_W(COORD_W)) u_switch (
        .clk             (clk),
        .rst             (rst),
        .loc_req_valid   (loc_req_valid),
        .loc_req_dir     (loc_req_dir),
        .loc_req_flit    (loc_req_flit),
        .lnk_req_valid   (lnk_req_valid),
        .lnk_req_dir     (lnk_req_dir),
        .lnk_req_flit    (lnk_req_flit),
        .loc_grant       (loc_grant),
        .lnk_grant       (lnk_grant),
        .local_out_data  (local_out_data),
        .local_out_valid (local_out_valid),
        .local_out_ready (local_out_ready),
        .north_out_data  (north_out_data),
        .north_out_valid (north_out_valid),
        .north_out_ready (north_out_ready),
        .south_out_data  (south_out_data),
        .south_out_valid (south_out_valid),
        .south_out_ready (south_out_ready),
        .east_out_data   (east_out_data),
        .east_out_valid  (east_out_valid),
        .east_out_ready  (east_out_ready),
        .west_out_data   (west_out_data),
        .west_out_valid  (west_out_valid),
        .west_out_ready  (west_out_ready)
    );

endmodule

`default_nettype wire

//--- tb_spike_router.sv
`default_nettype none

module tb_spike_router;

    localparam int COORD_W = 9;
    localparam int FLIT_W = 2 * COORD_W + spike_pkg::DELIVERY_W;
    localparam int NPORT = route_pkg::NUM_OUT_PORTS;
    localparam int RESET_CYCLES = 2;
    localparam int DIRECTED_PKTS = 12;
    localparam int RAND_PKTS = 300;
    // Nominal cycles of the reset, directed, contention and random phases
    localparam int STIM_CYCLES = RESET_CYCLES + 6 * DIRECTED_PKTS + 8 + 2 * RAND_PKTS;
    localparam int TIMEOUT_CYCLES = 4 * STIM_CYCLES;

    // Offsets for one packet per direction in east, west, north, south, local order
    localparam int DX_TAB [5] = '{3, -2, 0, 0, 0};
    localparam int DY_TAB [5] = '{1, 4, 5, -3, 0};

    logic                 clk;
    logic                 rst;
    logic [FLIT_W-1:0]    local_in_data;
    logic                 local_in_valid;
    logic                 local_in_ready;
    logic [FLIT_W-1:0]    link_in_data;
    logic                 link_in_valid;
    logic                 link_in_ready;
    spike_pkg::delivery_t local_out_data;
    logic [NPORT-1:0]     out_valid;
    logic [NPORT-1:0]     out_ready;
    logic [FLIT_W-1:0]    out_data [NPORT];

    // Expected words per source (0 local, 1 link) and output port
    logic [FLIT_W-1:0]    exp_q [2][NPORT][$];
    logic [FLIT_W-1:0]    head_loc [NPORT];
    logic [FLIT_W-1:0]    head_lnk [NPORT];
    logic [NPORT-1:0]     has_loc = '0;
    logic [NPORT-1:0]     has_lnk = '0;
    int                   pending = 0;

    logic [NPORT-1:0]     held = '0;
    logic [FLIT_W-1:0]    held_data [NPORT];

    logic [31:0]          lfsr_state = 32'hc3318e8b;
    int                   cycle_count = 0;

    spike_router #(.COORD_W(COORD_W)) u_dut (
        .clk             (clk),
        .rst             (rst),
        .local_in_data   (local_in_data),
        .local_in_valid  (local_in_valid),
        .local_in_ready  (local_in_ready),
        .link_in_data    (link_in_data),
        .link_in_valid   (link_in_valid),
        .link_in_ready   (link_in_ready),
        .local_out_data  (local_out_data),
        .local_out_valid (out_valid[route_pkg::DIR_LOCAL]),
        .local_out_ready (out_ready[route_pkg::DIR_LOCAL]),
        .north_out_data  (out_data[route_pkg::DIR_NORTH]),
        .north_out_valid (out_valid[route_pkg::DIR_NORTH]),
        .north_out_ready (out_ready[route_pkg::DIR_NORTH]),
        .south_out_data  (out_data[route_pkg::DIR_SOUTH]),
        .south_out_valid (out_valid[route_pkg::DIR_SOUTH]),
        .south_out_ready (out_ready[route_pkg::DIR_SOUTH]),
        .east_out_data   (out_data[route_pkg::DIR_EAST]),
        .east_out_valid  (out_valid[route_pkg::DIR_EAST]),
        .east_out_ready  (out_ready[route_pkg::DIR_EAST]),
        .west_out_data   (out_data[route_pkg::DIR_WEST]),
        .west_out_valid  (out_valid[route_pkg::DIR_WEST]),
        .west_out_ready  (out_ready[route_pkg::DIR_WEST])
    );

    assign out_data[route_pkg::DIR_LOCAL] = FLIT_W'(local_out_data);

    always #10 clk = ~clk;

    task automatic fail_run();
        $display("Test failures found");
        $fatal(1);
    endtask

    task automatic report_error(input string what);
        $display("Error at time %0t: %s", $time, what);
        fail_run();
    endtask

    task automatic report_mismatch(input string name, input logic [FLIT_W-1:0] expected,
                                   input logic [FLIT_W-1:0] actual);
        $display("Mismatch at time %0t: %s expected %h, actual %h", $time, name, expected, actual);
        fail_run();
    endtask

    function automatic string port_name(input int p);
        case (p)
            0: return "local";
            1: return "north";
            2: return "south";
            3: return "east";
            4: return "west";
            default: return "unknown";
        endcase
    endfunction

    // Galois LFSR stepped once per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < n; i++) begin
            if (lfsr_state[0]) begin
                lfsr_state = (lfsr_state >> 1) ^ 32'h80200003;
            end else begin
                lfsr_state = lfsr_state >> 1;
            end
            r = {r[30:0], lfsr_state[0]};
        end
        return r;
    endfunction

    function automatic spike_pkg::delivery_t rand_payload();
        return spike_pkg::delivery_t'(rand_bits(spike_pkg::DELIVERY_W));
    endfunction

    function automatic logic [FLIT_W-1:0] make_flit(input int dx, input int dy,
                                                    input spike_pkg::delivery_t payload);
        return {COORD_W'(dx), COORD_W'(dy), payload};
    endfunction

    // X before Y and local when both offsets are zero
    function automatic route_pkg::port_dir_e route_port(input logic [FLIT_W-1:0] f);
        int dx;
        int dy;
        dx = int'($signed(f[FLIT_W-1 -: COORD_W]));
        dy = int'($signed(f[FLIT_W-1-COORD_W -: COORD_W]));
        if (dx > 0) return route_pkg::DIR_EAST;
        if (dx < 0) return route_pkg::DIR_WEST;
        if (dy > 0) return route_pkg::DIR_NORTH;
        if (dy < 0) return route_pkg::DIR_SOUTH;
        return route_pkg::DIR_LOCAL;
    endfunction

    // Word expected on the output port after one hop
    function automatic logic [FLIT_W-1:0] next_hop(input logic [FLIT_W-1:0] f);
        int dx;
        int dy;
        spike_pkg::delivery_t payload;
        dx = int'($signed(f[FLIT_W-1 -: COORD_W]));
        dy = int'($signed(f[FLIT_W-1-COORD_W -: COORD_W]));
        payload = f[spike_pkg::DELIVERY_W-1:0];
        case (route_port(f))
            route_pkg::DIR_EAST: dx = dx - 1;
            route_pkg::DIR_WEST: dx = dx + 1;
            route_pkg::DIR_NORTH: begin
                dx = 0;
                dy = dy - 1;
            end
            route_pkg::DIR_SOUTH: begin
                dx = 0;
                dy = dy + 1;
            end
            default: return FLIT_W'(payload);
        endcase
        return make_flit(dx, dy, payload);
    endfunction

    function automatic logic [FLIT_W-1:0] rand_flit();
        int dx;
        int dy;
        dx = int'(rand_bits(3)) - 4;
        dy = int'(rand_bits(3)) - 4;
        return make_flit(dx, dy, rand_payload());
    endfunction

    // Called 2 units after an edge and returns 2 units after the accepting edge
    task automatic send_one(input int src, input logic [FLIT_W-1:0] f);
        logic accepted;
        accepted = 1'b0;
        if (src == 0) begin
            local_in_data = f;
            local_in_valid = 1'b1;
        end else begin
            link_in_data = f;
            link_in_valid = 1'b1;
        end
        while (!accepted) begin
            @(posedge clk);
            accepted = (src == 0) ? local_in_ready : link_in_ready;
            #2;
        end
        local_in_valid = 1'b0;
        link_in_valid = 1'b0;
    endtask

    task automatic wait_drained();
        do begin
            @(posedge clk);
            #1;
        end while (pending != 0 || out_valid != '0);
        #1;
    endtask

    // Scoreboard pops before pushes since latency is at least two edges
    always @(posedge clk) begin
        if (!rst) begin
            for (int p = 0; p < NPORT; p++) begin
                if (out_valid[p] && out_ready[p]) begin
                    if (has_loc[p] && exp_q[0][p][0] == out_data[p]) begin
                        void'(exp_q[0][p].pop_front());
                    end else if (has_lnk[p] && exp_q[1][p][0] == out_data[p]) begin
                        void'(exp_q[1][p].pop_front());
                    end
                end
            end
            if (local_in_valid && local_in_ready) begin
                exp_q[0][route_port(local_in_data)].push_back(next_hop(local_in_data));
            end
            if (link_in_valid && link_in_ready) begin
                exp_q[1][route_port(link_in_data)].push_back(next_hop(link_in_data));
            end
            pending = 0;
            for (int p = 0; p < NPORT; p++) begin
                has_loc[p] = exp_q[0][p].size() != 0;
                has_lnk[p] = exp_q[1][p].size() != 0;
                head_loc[p] = has_loc[p] ? exp_q[0][p][0] : '0;
                head_lnk[p] = has_lnk[p] ? exp_q[1][p][0] : '0;
                pending = pending + exp_q[0][p].size() + exp_q[1][p].size();
            end
        end
    end

    always @(posedge clk) begin
        for (int p = 0; p < NPORT; p++) begin
            held[p] <= out_valid[p] && !out_ready[p];
            held_data[p] <= out_data[p];
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            report_error($sformatf("timed out after %0d cycles with %0d packets still expected",
                                   cycle_count, pending));
        end
    end

    assert property (@(posedge clk) $fell(rst) |->
        (out_valid == '0 && local_in_ready && link_in_ready))
    else report_error("router not idle with both inputs ready after reset");

    for (genvar p = 0; p < NPORT; p++) begin : g_port_check
        // A transfer matches the oldest word of one of the two sources
        assert property (@(posedge clk) disable iff (rst)
            (out_valid[p] && out_ready[p]) |->
                ((has_loc[p] && out_data[p] == head_loc[p]) ||
                 (has_lnk[p] && out_data[p] == head_lnk[p])))
        else report_mismatch({port_name(p), "_out_data"},
            $sampled(has_loc[p]) ? $sampled(head_loc[p]) : $sampled(head_lnk[p]),
            $sampled(out_data[p]));

        assert property (@(posedge clk) disable iff (rst) held[p] |-> out_valid[p])
        else report_error({port_name(p), "_out_valid dropped while ready was low"});

        assert property (@(posedge clk) disable iff (rst)
            held[p] |-> (out_data[p] == held_data[p]))
        else report_mismatch({port_name(p), "_out_data"}, $sampled(held_data[p]),
            $sampled(out_data[p]));
    end

    initial begin
        logic [FLIT_W-1:0] loc_f;
        logic [FLIT_W-1:0] lnk_f;
        logic              both;
        logic              loc_acc;
        logic              lnk_acc;
        int                loc_left;
        int                lnk_left;

        clk = 1'b0;
        rst = 1'b1;
        local_in_data = '0;
        local_in_valid = 1'b0;
        link_in_data = '0;
        link_in_valid = 1'b0;
        out_ready = '1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;

        // Each direction from each input, one packet at a time
        for (int src = 0; src < 2; src++) begin
            for (int i = 0; i < 5; i++) begin
                send_one(src, make_flit(DX_TAB[i], DY_TAB[i], rand_payload()));
                wait_drained();
            end
        end
        // Extreme offsets
        send_one(0, make_flit(255, 0, rand_payload()));
        wait_drained();
        send_one(1, make_flit(-256, -256, rand_payload()));
        wait_drained();

        // Both inputs aim east in the same cycle
        loc_f = make_flit(2, 0, rand_payload());
        lnk_f = make_flit(4, -1, rand_payload());
        local_in_data = loc_f;
        link_in_data = lnk_f;
        local_in_valid = 1'b1;
        link_in_valid = 1'b1;
        @(posedge clk);
        both = local_in_ready && link_in_ready;
        #2;
        local_in_valid = 1'b0;
        link_in_valid = 1'b0;
        if (!both) begin
            report_error("empty router did not accept both inputs in one cycle");
        end
        do begin
            @(posedge clk);
            #1;
        end while (!out_valid[route_pkg::DIR_EAST]);
        assert (out_data[route_pkg::DIR_EAST] == next_hop(loc_f))
        else report_mismatch("east_out_data", next_hop(loc_f), out_data[route_pkg::DIR_EAST]);
        wait_drained();

        // Random traffic with random back-pressure
        loc_left = RAND_PKTS;
        lnk_left = RAND_PKTS;
        while (loc_left > 0 || lnk_left > 0 || local_in_valid || link_in_valid) begin
            if (!local_in_valid && loc_left > 0 && rand_bits(2) != 0) begin
                local_in_data = rand_flit();
                local_in_valid = 1'b1;
                loc_left--;
            end
            if (!link_in_valid && lnk_left > 0 && rand_bits(2) != 0) begin
                link_in_data = rand_flit();
                link_in_valid = 1'b1;
                lnk_left--;
            end
            for (int p = 0; p < NPORT; p++) begin
                out_ready[p] = rand_bits(2) != 0;
            end
            @(posedge clk);
            loc_acc = local_in_valid && local_in_ready;
            lnk_acc = link_in_valid && link_in_ready;
            #2;
            if (loc_acc) local_in_valid = 1'b0;
            if (lnk_acc) link_in_valid = 1'b0;
        end
        out_ready = '1;
        wait_drained();
        repeat (4) @(posedge clk);
        #1;

        if (pending == 0 && out_valid == '0) begin
            $display("All tests passed!");
            $finish;
        end else begin
            report_error("packets left over after the router drained");
        end
    end

endmodule

`default_nettype wire

//--- Bender.yml
package:
  name: spike_router

sources:
  - spike_pkg.sv
  - route_pkg.sv
  - input_port.sv
  - output_switch.sv
  - spike_router.sv
  - target: simulation
    files:
      - tb_spike_router.sv

//--- project.f
spike_pkg.sv
route_pkg.sv
input_port.sv
output_switch.sv
spike_router.sv
tb_spike_router.sv
